// File: verilog/loader_pkg.sv
// Download port, RAM write and cartridge record types; RAM addresses are 25 bits and bytes are 8
package loader_pkg;

	// ========================================
	// Basic types
	// ========================================
	typedef logic [24:0] ram_addr_t;

	// Host download port as one bundle
	typedef struct packed {
		logic       download;
		logic       wr;
		logic [7:0] index;
		ram_addr_t  addr;
		logic [7:0] data;
	} ioctl_bus_t;

	// One byte write to external RAM
	typedef struct packed {
		ram_addr_t  addr;
		logic [7:0] data;
	} mem_wr_t;

	typedef struct packed {
		logic [15:0] id;
		logic [7:0]  exrom;
		logic [7:0]  game;
	} crt_info_t;

	// Chip packet record, big-endian fields as in the CRT file
	typedef struct packed {
		logic [7:0]  chip_type;
		logic [15:0] bank;
		logic [15:0] load_addr;
		logic [15:0] size;
	} bank_rec_t;

	// ========================================
	// File indices and addresses
	// ========================================
	localparam logic [7:0] IDX_PRG     = 8'd4;
	localparam logic [7:0] IDX_CRT     = 8'd5;
	localparam logic [7:0] IDX_CRT_ALT = 8'hC0;
	localparam logic [7:0] IDX_TAP     = 8'd6;

	localparam ram_addr_t CRT_BASE   = 25'h100000;
	localparam ram_addr_t TAP_BASE   = 25'h200000;
	localparam ram_addr_t ERASE_LAST = 25'h00FFFF;

	localparam int ERASE_GAP = 32;

	// CRT file layout
	localparam ram_addr_t CRT_CHIP_START   = 25'h40;
	localparam int        CRT_CHIP_HDR_LEN = 16;
	localparam ram_addr_t CRT_OFS_ID       = 25'h16;
	localparam ram_addr_t CRT_OFS_EXROM    = 25'h18;
	localparam ram_addr_t CRT_OFS_GAME     = 25'h19;

	// Both cartridge indices load the same way
	function automatic logic is_crt_index(input logic [7:0] idx);
		return (idx == IDX_CRT) || (idx == IDX_CRT_ALT);
	endfunction

endpackage

// File: verilog/audio_pkg.sv
// Mixer types; sound-chip samples are 18-bit signed, FM and outputs are 16-bit signed
package audio_pkg;

	typedef struct packed {
		logic signed [17:0] sid_l;
		logic signed [17:0] sid_r;
		logic signed [15:0] fm;
		logic               fm_en;
		logic               tape;
	} audio_src_t;

	typedef struct packed {
		logic signed [15:0] left;
		logic signed [15:0] right;
	} audio_out_t;

	// Output clamp range
	localparam int AUD_MAX = 32767;
	localparam int AUD_MIN = -32768;

	// Tape click weight
	localparam int TAPE_SHIFT = 10;

endpackage

// File: verilog/crt_header_parser.sv
// Expects a CRT file starting at offset 0; chip packets must follow each other without gaps
`timescale 1ns/1ps

module crt_header_parser import loader_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_n,
	input  ioctl_bus_t ioctl_i,
	output logic       payload_o,
	output logic       align_o,
	output logic       bank_wr_o,
	output logic       cart_attached_o,
	output crt_info_t  crt_info_o,
	output bank_rec_t  bank_rec_o
);

	logic        crt_wr;
	logic        chip_byte;
	logic        old_download;
	logic [3:0]  hdr_cnt;
	logic [31:0] blk_len;

	assign crt_wr    = ioctl_i.wr && is_crt_index(ioctl_i.index);
	assign chip_byte = crt_wr && (ioctl_i.addr >= CRT_CHIP_START);

	// A new chip header starts when the last packet is used up
	assign align_o   = chip_byte && (blk_len == '0) && (hdr_cnt == '0);
	assign payload_o = chip_byte && (blk_len != '0) && (hdr_cnt == '0);

	// ========================================
	// Chip header counter and attach state
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			hdr_cnt         <= '0;
			blk_len         <= '0;
			bank_wr_o       <= 1'b0;
			old_download    <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			old_download <= ioctl_i.download;
			bank_wr_o    <= 1'b0;

			if (crt_wr && ioctl_i.addr == '0) begin
				hdr_cnt <= '0;
				blk_len <= '0;
			end else if (align_o) begin
				hdr_cnt <= 4'd1;
			end else if (chip_byte && hdr_cnt != '0) begin
				hdr_cnt <= hdr_cnt + 4'd1;
				// Packet length is big-endian and includes the header
				case (hdr_cnt)
					4'd4: blk_len[31:24] <= ioctl_i.data;
					4'd5: blk_len[23:16] <= ioctl_i.data;
					4'd6: blk_len[15:8]  <= ioctl_i.data;
					4'd7: blk_len[7:0]   <= ioctl_i.data;
					4'd8: blk_len        <= blk_len - 32'(CRT_CHIP_HDR_LEN);
					default: ;
				endcase
				if (hdr_cnt == 4'(CRT_CHIP_HDR_LEN - 1))
					bank_wr_o <= 1'b1;
			end else if (payload_o) begin
				blk_len <= blk_len - 32'd1;
			end

			// Detached while loading, attached once the file is complete
			if (old_download != ioctl_i.download && is_crt_index(ioctl_i.index))
				cart_attached_o <= old_download;
		end
	end

	// ========================================
	// Header fields
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (crt_wr) begin
			if (ioctl_i.addr == CRT_OFS_ID)         crt_info_o.id[15:8] <= ioctl_i.data;
			if (ioctl_i.addr == CRT_OFS_ID + 25'd1) crt_info_o.id[7:0]  <= ioctl_i.data;
			if (ioctl_i.addr == CRT_OFS_EXROM)      crt_info_o.exrom    <= ioctl_i.data;
			if (ioctl_i.addr == CRT_OFS_GAME)       crt_info_o.game     <= ioctl_i.data;
		end
		if (chip_byte) begin
			case (hdr_cnt)
				4'd9:  bank_rec_o.chip_type       <= ioctl_i.data;
				4'd10: bank_rec_o.bank[15:8]      <= ioctl_i.data;
				4'd11: bank_rec_o.bank[7:0]       <= ioctl_i.data;
				4'd12: bank_rec_o.load_addr[15:8] <= ioctl_i.data;
				4'd13: bank_rec_o.load_addr[7:0]  <= ioctl_i.data;
				4'd14: bank_rec_o.size[15:8]      <= ioctl_i.data;
				4'd15: bank_rec_o.size[7:0]       <= ioctl_i.data;
				default: ;
			endcase
		end
	end

endmodule

// File: verilog/load_addr_gen.sv
// Host must not write while a request is outstanding; erase start is ignored while erasing
`timescale 1ns/1ps

module load_addr_gen import loader_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_n,
	input  ioctl_bus_t ioctl_i,
	input  logic       payload_i,
	input  logic       align_i,
	input  logic       erase_start_i,
	input  logic       issued_i,
	output logic       req_o,
	output mem_wr_t    req_wr_o
);

	ram_addr_t  load_addr;
	ram_addr_t  cur_addr;
	ram_addr_t  wr_addr;
	logic       prg_wr;
	logic       tap_wr;
	logic       store_byte;
	logic       erasing;
	logic       erase_wait;
	logic [5:0] erase_to;

	// The address moves on as soon as the writer reports the issue
	assign cur_addr = issued_i ? load_addr + 25'd1 : load_addr;

	assign prg_wr = ioctl_i.index == IDX_PRG;
	assign tap_wr = ioctl_i.index == IDX_TAP;

	// PRG skips the two address bytes, cartridge stores only payload
	assign store_byte = (prg_wr && ioctl_i.addr > 25'd1) || payload_i || tap_wr;
	assign wr_addr    = (tap_wr && ioctl_i.addr == '0) ? TAP_BASE : cur_addr;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			load_addr  <= '0;
			req_o      <= 1'b0;
			erasing    <= 1'b0;
			erase_wait <= 1'b0;
			erase_to   <= '0;
		end else begin
			req_o     <= 1'b0;
			load_addr <= cur_addr;

			if (erasing) begin
				if (issued_i) begin
					erase_wait <= 1'b0;
					if (load_addr == ERASE_LAST)
						erasing <= 1'b0;
				end else if (!erase_wait) begin
					erase_to <= erase_to + 6'd1;
					if (erase_to == 6'(ERASE_GAP - 1)) begin
						erase_to   <= '0;
						erase_wait <= 1'b1;
						req_o      <= 1'b1;
					end
				end
			end else if (erase_start_i) begin
				erasing    <= 1'b1;
				erase_wait <= 1'b0;
				erase_to   <= '0;
				load_addr  <= '0;
			end else if (ioctl_i.wr) begin
				req_o <= store_byte;

				// PRG load address comes from the file itself
				if (prg_wr && ioctl_i.addr == '0)
					load_addr <= ram_addr_t'(ioctl_i.data);
				if (prg_wr && ioctl_i.addr == 25'd1)
					load_addr[15:8] <= ioctl_i.data;

				if (is_crt_index(ioctl_i.index) && ioctl_i.addr == '0)
					load_addr <= CRT_BASE;
				// Round up to the next 8 KB bank unless already aligned
				if (align_i && cur_addr[12:0] != '0)
					load_addr <= {cur_addr[24:13] + 12'd1, 13'd0};

				if (tap_wr && ioctl_i.addr == '0)
					load_addr <= TAP_BASE;
			end
		end
	end

	// Striped fill while erasing, host byte otherwise
	always_ff @(posedge clk_sys) begin
		if (erasing)
			req_wr_o <= '{addr: load_addr, data: {8{load_addr[6]}}};
		else
			req_wr_o <= '{addr: wr_addr, data: ioctl_i.data};
	end

endmodule

// File: verilog/mem_slot_writer.sv
// Holds a single write; a new request must not arrive while one is pending
`timescale 1ns/1ps

module mem_slot_writer import loader_pkg::*; (
	input  logic    clk_sys,
	input  logic    reset_n,
	input  logic    slot_i,
	input  logic    req_i,
	input  mem_wr_t req_wr_i,
	output logic    busy_o,
	output logic    issued_o,
	output logic    mem_we_o,
	output mem_wr_t mem_o
);

	logic    slot_d;
	logic    slot_fall;
	logic    pending;
	mem_wr_t pend_wr;

	assign slot_fall = slot_d && !slot_i;

	// Busy already in the request cycle so the host stalls at once
	assign busy_o = pending || req_i;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			slot_d   <= 1'b0;
			pending  <= 1'b0;
			issued_o <= 1'b0;
			mem_we_o <= 1'b0;
		end else begin
			slot_d   <= slot_i;
			issued_o <= 1'b0;
			mem_we_o <= 1'b0;
			if (req_i) begin
				pending <= 1'b1;
			end else if (pending && slot_fall) begin
				pending  <= 1'b0;
				issued_o <= 1'b1;
				mem_we_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (req_i)
			pend_wr <= req_wr_i;
		if (pending && slot_fall && !req_i)
			mem_o <= pend_wr;
	end

endmodule

// File: verilog/audio_mixer.sv
// Two-cycle mixer; the 17-bit sum can wrap only when both sources sit at full scale
`timescale 1ns/1ps

module audio_mixer import audio_pkg::*; (
	input  logic       clk_sys,
	input  audio_src_t audio_i,
	output audio_out_t audio_o
);

	logic signed [16:0] sum_l;
	logic signed [16:0] sum_r;

	function automatic logic signed [16:0] mix(
		input logic signed [17:0] sid,
		input logic signed [15:0] fm,
		input logic               fm_en,
		input logic               tape
	);
		logic signed [16:0] acc;
		acc = 17'(sid >>> 2);
		if (fm_en)
			acc = acc + 17'(fm);
		acc = acc + (17'(tape) << TAPE_SHIFT);
		return acc;
	endfunction

	function automatic logic signed [15:0] clamp(input logic signed [16:0] v);
		if (v > AUD_MAX)
			return 16'(AUD_MAX);
		else if (v < AUD_MIN)
			return 16'(AUD_MIN);
		else
			return v[15:0];
	endfunction

	// Stage 1 sums, stage 2 clamps
	always_ff @(posedge clk_sys) begin
		sum_l         <= mix(audio_i.sid_l, audio_i.fm, audio_i.fm_en, audio_i.tape);
		sum_r         <= mix(audio_i.sid_r, audio_i.fm, audio_i.fm_en, audio_i.tape);
		audio_o.left  <= clamp(sum_l);
		audio_o.right <= clamp(sum_r);
	end

endmodule

// File: verilog/c64_loader_top.sv
// RAM writes go out only in the slot given by slot_i; the host must honour ioctl_wait_o
`timescale 1ns/1ps

module c64_loader_top import loader_pkg::*, audio_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_n,
	input  ioctl_bus_t ioctl_i,
	input  logic       slot_i,
	input  logic       erase_start_i,
	input  audio_src_t audio_i,
	output logic       ioctl_wait_o,
	output logic       mem_we_o,
	output mem_wr_t    mem_o,
	output crt_info_t  crt_info_o,
	output bank_rec_t  bank_rec_o,
	output logic       bank_wr_o,
	output logic       cart_attached_o,
	output audio_out_t audio_o
);

	logic    payload;
	logic    align;
	logic    req;
	logic    issued;
	mem_wr_t req_wr;

	// ========================================
	// Loader path
	// ========================================
	crt_header_parser u_crt_parser (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.ioctl_i         (ioctl_i),
		.payload_o       (payload),
		.align_o         (align),
		.bank_wr_o       (bank_wr_o),
		.cart_attached_o (cart_attached_o),
		.crt_info_o      (crt_info_o),
		.bank_rec_o      (bank_rec_o)
	);

	load_addr_gen u_addr_gen (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.ioctl_i       (ioctl_i),
		.payload_i     (payload),
		.align_i       (align),
		.erase_start_i (erase_start_i),
		.issued_i      (issued),
		.req_o         (req),
		.req_wr_o      (req_wr)
	);

	// Host waits while a write is pending
	mem_slot_writer u_writer (
		.clk_sys  (clk_sys),
		.reset_n  (reset_n),
		.slot_i   (slot_i),
		.req_i    (req),
		.req_wr_i (req_wr),
		.busy_o   (ioctl_wait_o),
		.issued_o (issued),
		.mem_we_o (mem_we_o),
		.mem_o    (mem_o)
	);

	// ========================================
	// Audio
	// ========================================
	audio_mixer u_mixer (
		.clk_sys (clk_sys),
		.audio_i (audio_i),
		.audio_o (audio_o)
	);

endmodule

// File: tests/tb_tasks.svh
// Included in tb_top; all tasks start and end on a falling clock edge

// ========================================
// Helpers and compare tasks
// ========================================
function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state;
endfunction

task automatic check_mem(string name, mem_wr_t exp, mem_wr_t act);
	if (act !== exp) begin
		err_count++;
		$display("** Error: %s expected %h got %h", name, exp, act);
	end
endtask

task automatic check_crt(string name, crt_info_t exp, crt_info_t act);
	if (act !== exp) begin
		err_count++;
		$display("** Error: %s expected %h got %h", name, exp, act);
	end
endtask

task automatic check_bank(string name, bank_rec_t exp, bank_rec_t act);
	if (act !== exp) begin
		err_count++;
		$display("** Error: %s expected %h got %h", name, exp, act);
	end
endtask

task automatic check_audio(string name, audio_out_t exp, audio_out_t act);
	if (act !== exp) begin
		err_count++;
		$display("** Error: %s expected %h got %h", name, exp, act);
	end
endtask

task automatic check_flag(string name, logic exp, logic act);
	if (act !== exp) begin
		err_count++;
		$display("** Error: %s expected %h got %h", name, exp, act);
	end
endtask

task automatic check_stored(string name, ram_addr_t a, logic [7:0] d);
	mem_wr_t exp;
	mem_wr_t act;
	exp = '{addr: a, data: d};
	if (!mem.exists(a)) begin
		err_count++;
		$display("%s: no write ever reached address %h", name, a);
	end else begin
		act = '{addr: a, data: mem[a]};
		check_mem(name, exp, act);
	end
endtask

task automatic check_count(string name, int exp, int act);
	if (act != exp) begin
		err_count++;
		$display("%s: saw %0d writes where %0d were due", name, act, exp);
	end
endtask

task automatic end_test(string name, int e0);
	test_count++;
	if (err_count == e0) begin
		$display("%s: passed", name);
	end else begin
		test_fail++;
		$display("%s: failed with %0d errors", name, err_count - e0);
	end
endtask

// ========================================
// Waits and host port stimulus
// ========================================
task automatic wait_host_ready();
	int n;
	n = 0;
	while (!hung && ioctl_wait_o && n < 200) begin
		@(negedge clk_sys);
		n++;
	end
	if (!hung && ioctl_wait_o) begin
		hung = 1'b1;
		err_count++;
		$display("Timeout: the host wait signal never dropped");
	end
endtask

task automatic wait_writes(int target, int limit);
	int n;
	n = 0;
	while (!hung && wr_count < target && n < limit) begin
		@(negedge clk_sys);
		n++;
	end
	if (!hung && wr_count < target) begin
		hung = 1'b1;
		err_count++;
		$display("Timeout: only %0d of %0d RAM writes arrived", wr_count, target);
	end
endtask

// Slot levels as the DUT sampled them on the last two rising edges
task automatic wait_slot_high();
	int n;
	n = 0;
	while (!hung && !(slot_s1 && !slot_s2) && n < 20) begin
		@(negedge clk_sys);
		n++;
	end
	if (!hung && !(slot_s1 && !slot_s2)) begin
		hung = 1'b1;
		err_count++;
		$display("Timeout: the memory slot never opened");
	end
endtask

task automatic host_write(ram_addr_t ofs, logic [7:0] d);
	wait_host_ready();
	ioctl.wr   = 1'b1;
	ioctl.addr = ofs;
	ioctl.data = d;
	@(negedge clk_sys);
	ioctl.wr = 1'b0;
endtask

task automatic start_download(logic [7:0] idx);
	ioctl.index    = idx;
	ioctl.download = 1'b1;
	@(negedge clk_sys);
endtask

task automatic finish_download(int target);
	wait_writes(target, 2000);
	ioctl.download = 1'b0;
	repeat (2) @(negedge clk_sys);
endtask

// ========================================
// Expected data
// ========================================
function automatic logic [7:0] chip_hdr_byte(int i, bank_rec_t rec);
	case (i)
		0: return 8'h43;
		1: return 8'h48;
		2: return 8'h49;
		3: return 8'h50;
		7: return 8'h20;
		9: return rec.chip_type;
		10: return rec.bank[15:8];
		11: return rec.bank[7:0];
		12: return rec.load_addr[15:8];
		13: return rec.load_addr[7:0];
		14: return rec.size[15:8];
		15: return rec.size[7:0];
		default: return 8'h00;
	endcase
endfunction

function automatic logic [7:0] crt_hdr_byte(int i, crt_info_t info);
	case (i)
		'h16: return info.id[15:8];
		'h17: return info.id[7:0];
		'h18: return info.exrom;
		'h19: return info.game;
		default: return (i < 16) ? 8'h43 : 8'h00;
	endcase
endfunction

function automatic logic [15:0] sat16(int v);
	if (v > AUD_MAX)
		return 16'(AUD_MAX);
	if (v < AUD_MIN)
		return 16'(AUD_MIN);
	return 16'(v);
endfunction

// Sound chip scaled by 1/4, plus FM when enabled, plus tape click
function automatic audio_out_t mix_expect(audio_src_t s);
	int f;
	int t;
	int l;
	int r;
	audio_out_t o;
	f = s.fm_en ? int'($signed(s.fm)) : 0;
	t = s.tape ? (1 << TAPE_SHIFT) : 0;
	l = (int'($signed(s.sid_l)) >>> 2) + f + t;
	r = (int'($signed(s.sid_r)) >>> 2) + f + t;
	o.left  = sat16(l);
	o.right = sat16(r);
	return o;
endfunction

// ========================================
// Directed tests
// ========================================
task automatic test_reset_state();
	int e0;
	e0 = err_count;
	check_flag("mem_we_o", 1'b0, mem_we_o);
	check_flag("bank_wr_o", 1'b0, bank_wr_o);
	check_flag("ioctl_wait_o", 1'b0, ioctl_wait_o);
	check_flag("cart_attached_o", 1'b0, cart_attached_o);
	repeat (50) @(negedge clk_sys);
	check_count("idle after reset", 0, wr_count);
	end_test("reset_state", e0);
endtask

task automatic test_prg_load();
	int e0;
	int base;
	int i;
	e0   = err_count;
	base = wr_count;
	start_download(IDX_PRG);
	host_write(25'd0, 8'h01);
	host_write(25'd1, 8'h08);
	for (i = 0; i < 20; i++)
		host_write(25'(i + 2), 8'(i * 37 + 5));
	finish_download(base + 20);
	check_count("prg_load", 20, wr_count - base);
	for (i = 0; i < 20; i++)
		check_stored("prg mem", 25'h0801 + 25'(i), 8'(i * 37 + 5));
	end_test("prg_load", e0);
endtask

task automatic test_tape_load();
	int e0;
	int base;
	int i;
	e0   = err_count;
	base = wr_count;
	start_download(IDX_TAP);
	for (i = 0; i < 12; i++)
		host_write(25'(i), 8'hA0 ^ 8'(i * 3));
	finish_download(base + 12);
	check_count("tape_load", 12, wr_count - base);
	for (i = 0; i < 12; i++)
		check_stored("tape mem", TAP_BASE + 25'(i), 8'hA0 ^ 8'(i * 3));
	end_test("tape_load", e0);
endtask

task automatic test_crt_load();
	int        e0;
	int        base;
	int        banks0;
	int        chip;
	int        i;
	ram_addr_t ofs;
	crt_info_t info;
	bank_rec_t recs[2];
	e0     = err_count;
	base   = wr_count;
	banks0 = bank_q.size();
	info   = '{id: 16'h0020, exrom: 8'h01, game: 8'h00};
	start_download(IDX_CRT);
	for (i = 0; i < 64; i++) begin
		host_write(25'(i), crt_hdr_byte(i, info));
		check_flag("ioctl_wait_o", 1'b0, ioctl_wait_o);
	end
	check_crt("crt_info_o", info, crt_info_o);
	ofs = CRT_CHIP_START;
	for (chip = 0; chip < 2; chip++) begin
		recs[chip] = '{chip_type: 8'(chip + 1), bank: 16'(chip), load_addr: 16'h8000,
			size: 16'h0010};
		for (i = 0; i < 16; i++) begin
			host_write(ofs, chip_hdr_byte(i, recs[chip]));
			check_flag("ioctl_wait_o", 1'b0, ioctl_wait_o);
			ofs++;
		end
		for (i = 0; i < 16; i++) begin
			host_write(ofs, 8'(chip * 64 + i * 5 + 1));
			ofs++;
		end
	end
	check_flag("cart_attached_o", 1'b0, cart_attached_o);
	finish_download(base + 32);
	check_flag("cart_attached_o", 1'b1, cart_attached_o);
	check_count("crt_load", 32, wr_count - base);
	if (bank_q.size() - banks0 != 2) begin
		err_count++;
		$display("crt_load: %0d bank records seen, two expected", bank_q.size() - banks0);
	end else begin
		check_bank("bank_rec_o", recs[0], bank_q[banks0]);
		check_bank("bank_rec_o", recs[1], bank_q[banks0 + 1]);
	end
	for (i = 0; i < 16; i++) begin
		check_stored("crt mem", CRT_BASE + 25'(i), 8'(i * 5 + 1));
		check_stored("crt mem", CRT_BASE + 25'h2000 + 25'(i), 8'(64 + i * 5 + 1));
	end
	end_test("crt_load", e0);
endtask

task automatic test_back_pressure();
	int e0;
	int base;
	int n;
	e0   = err_count;
	base = wr_count;
	start_download(IDX_TAP);
	wait_slot_high();
	host_write(25'd0, 8'h5A);
	check_flag("ioctl_wait_o", 1'b1, ioctl_wait_o);
	n = 0;
	while (slot_s1 && n < 20) begin
		check_flag("mem_we_o", 1'b0, mem_we_o);
		check_flag("ioctl_wait_o", 1'b1, ioctl_wait_o);
		@(negedge clk_sys);
		n++;
	end
	finish_download(base + 1);
	check_count("back_pressure", 1, wr_count - base);
	check_stored("stalled byte", TAP_BASE, 8'h5A);
	end_test("back_pressure", e0);
endtask

task automatic test_erase();
	int        e0;
	int        base;
	int        i;
	ram_addr_t a;
	e0          = err_count;
	base        = wr_count;
	erase_start = 1'b1;
	@(negedge clk_sys);
	erase_start = 1'b0;
	wait_writes(base + 65536, 4000000);
	repeat (100) @(negedge clk_sys);
	check_count("erase", 65536, wr_count - base);
	check_stored("erase mem", 25'h0000, 8'h00);
	check_stored("erase mem", 25'h003F, 8'h00);
	check_stored("erase mem", 25'h0040, 8'hFF);
	check_stored("erase mem", 25'h0801, 8'h00);
	check_stored("erase mem", 25'hFFFF, 8'hFF);
	for (i = 0; i < 16; i++) begin
		a = 25'(lcg_next() >> 12) & ERASE_LAST;
		check_stored("erase mem", a, a[6] ? 8'hFF : 8'h00);
	end
	end_test("erase", e0);
endtask

task automatic test_audio();
	int          e0;
	int          k;
	logic [31:0] r;
	audio_src_t  s;
	audio_out_t  exp_q[$];
	audio_src_t  corner[6];
	e0 = err_count;
	corner[0] = '{sid_l: 18'h1FFFF, sid_r: 18'h20000, fm: 16'h7FFF, fm_en: 1'b1, tape: 1'b0};
	corner[1] = '{sid_l: 18'h20000, sid_r: 18'h1FFFF, fm: 16'h8000, fm_en: 1'b1, tape: 1'b0};
	corner[2] = '{sid_l: 18'h1FFFF, sid_r: 18'h1FFFF, fm: 16'h8000, fm_en: 1'b0, tape: 1'b1};
	corner[3] = '{sid_l: 18'h20000, sid_r: 18'h20000, fm: 16'h8000, fm_en: 1'b1, tape: 1'b1};
	corner[4] = '{sid_l: 18'h00000, sid_r: 18'h00000, fm: 16'h0000, fm_en: 1'b0, tape: 1'b1};
	corner[5] = '{sid_l: 18'h00004, sid_r: 18'h3FFFC, fm: 16'hFFFF, fm_en: 1'b0, tape: 1'b0};
	for (k = 0; k < 72; k++) begin
		if (k >= 2)
			check_audio("audio_o", exp_q.pop_front(), audio_o);
		if (k < 70) begin
			if (k < 64) begin
				r       = lcg_next();
				s.sid_l = 18'(r >> 8);
				r       = lcg_next();
				s.sid_r = 18'(r >> 8);
				r       = lcg_next();
				// FM kept to 15-bit range so the 17-bit sum cannot wrap
				s.fm    = {r[22], r[22:8]};
				s.fm_en = r[4];
				s.tape  = r[5];
			end else begin
				s = corner[k - 64];
			end
			audio_src = s;
			exp_q.push_back(mix_expect(s));
		end
		@(negedge clk_sys);
	end
	end_test("audio", e0);
endtask

// File: tests/tb_top.sv
// Slot is high 3 of every 8 cycles; the erase test alone runs close to 3M clock cycles
`timescale 1ns/1ps

module tb_top import loader_pkg::*, audio_pkg::*; ();

	logic       clk_sys;
	logic       reset_n;
	ioctl_bus_t ioctl;
	logic       slot_i;
	logic       erase_start;
	audio_src_t audio_src;
	logic       ioctl_wait_o;
	logic       mem_we_o;
	mem_wr_t    mem_o;
	crt_info_t  crt_info_o;
	bank_rec_t  bank_rec_o;
	logic       bank_wr_o;
	logic       cart_attached_o;
	audio_out_t audio_o;

	// Memory model and bank record log
	logic [7:0]  mem [ram_addr_t];
	int          wr_count;
	bank_rec_t   bank_q[$];
	logic [2:0]  slot_cnt;
	logic        slot_s1;
	logic        slot_s2;
	logic [31:0] lcg_state;
	int          err_count;
	int          test_count;
	int          test_fail;
	logic        hung;

	c64_loader_top dut (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.ioctl_i         (ioctl),
		.slot_i          (slot_i),
		.erase_start_i   (erase_start),
		.audio_i         (audio_src),
		.ioctl_wait_o    (ioctl_wait_o),
		.mem_we_o        (mem_we_o),
		.mem_o           (mem_o),
		.crt_info_o      (crt_info_o),
		.bank_rec_o      (bank_rec_o),
		.bank_wr_o       (bank_wr_o),
		.cart_attached_o (cart_attached_o),
		.audio_o         (audio_o)
	);

	initial clk_sys = 1'b0;
	always #2 clk_sys = ~clk_sys;

	always @(negedge clk_sys) begin
		slot_cnt = slot_cnt + 3'd1;
		slot_i   = slot_cnt < 3'd3;
	end

	// ========================================
	// Write capture and slot rule monitor
	// ========================================
	always @(posedge clk_sys) begin
		if (mem_we_o) begin
			mem[mem_o.addr] = mem_o.data;
			wr_count++;
			if (!(slot_s2 && !slot_s1)) begin
				err_count++;
				$display("RAM write issued outside the falling edge of the slot");
			end
		end
		if (bank_wr_o)
			bank_q.push_back(bank_rec_o);
		slot_s2 = slot_s1;
		slot_s1 = slot_i;
	end

	`include "tb_tasks.svh"

	initial begin
		ioctl       = '0;
		slot_i      = 1'b0;
		slot_cnt    = '0;
		slot_s1     = 1'b0;
		slot_s2     = 1'b0;
		erase_start = 1'b0;
		audio_src   = '0;
		reset_n     = 1'b0;
		wr_count    = 0;
		err_count   = 0;
		test_count  = 0;
		test_fail   = 0;
		hung        = 1'b0;
		lcg_state   = 32'd96317;
		repeat (10) @(negedge clk_sys);
		reset_n = 1'b1;
		@(negedge clk_sys);

		test_reset_state();
		test_prg_load();
		test_tape_load();
		test_crt_load();
		test_back_pressure();
		test_erase();
		test_audio();

		$display("tests run %0d, failed %0d, errors %0d", test_count, test_fail, err_count);
		if (err_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: tb.f
verilog/loader_pkg.sv
verilog/audio_pkg.sv
verilog/crt_header_parser.sv
verilog/load_addr_gen.sv
verilog/mem_slot_writer.sv
verilog/audio_mixer.sv
verilog/c64_loader_top.sv
+incdir+tests
tests/tb_top.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module tb_top -f tb.f -o Vtb_top

run: build
	./obj_dir/Vtb_top | tee sim.log
	grep -q "RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing --top-module tb_top -f tb.f

clean:
	rm -rf obj_dir sim.log
